// ==== compile.f ====
mem_stage_pkg.sv
mem_access_ctrl.sv
data_memory.sv
mem_wb_latch.sv
mem_stage.sv
tb_mem_stage.sv

// ==== data_memory.sv ====
`timescale 1ns/1ps

module data_memory
(
	input  logic                                     clk,
	input  logic                                     reset,
	input  logic                                     mem_write,   // Store strobe
	input  mem_stage_pkg::acc_size_t                 store_size,  // Shape of the stored value
	input  logic [mem_stage_pkg::mem_index_width-1:0] index,       // Word being accessed
	input  logic [mem_stage_pkg::data_width-1:0]      store_data,  // Raw store operand
	output logic [mem_stage_pkg::data_width-1:0]      mem_rdata,   // Asynchronous read
	output logic [mem_stage_pkg::data_width-1:0]      dbg_word0,   // Debug tap on word 0
	output logic [mem_stage_pkg::data_width-1:0]      dbg_word1,   // Debug tap on word 1
	output logic [mem_stage_pkg::data_width-1:0]      dbg_word2,   // Debug tap on word 2
	output logic [mem_stage_pkg::data_width-1:0]      dbg_word3    // Debug tap on word 3
);

	import mem_stage_pkg::*;

	logic [data_width-1:0] mem [mem_words];  // Word array
	logic [data_width-1:0] store_word;       // Store operand after shaping

	// Half and byte stores cover the whole word with the extended value
	always_comb
	begin
		case (store_size)
			SIZE_HALF:
			begin
				store_word = {{(data_width-16){store_data[15]}}, store_data[15:0]};
			end
			SIZE_BYTE:
			begin
				store_word = {{(data_width-8){store_data[7]}}, store_data[7:0]};
			end
			SIZE_WORD:
			begin
				store_word = store_data;
			end
			default:
			begin
				store_word = store_data;
			end
		endcase
	end

	// The whole array is cleared by reset so loads after reset return zero
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < mem_words; i++)
			begin
				mem[i] <= '0;
			end
		end
		else if (mem_write)
		begin
			mem[index] <= store_word;  // No alignment check, the index is the raw low bits
		end
	end

	// Loads see the array as it stood before this cycle's store
	assign mem_rdata = mem[index];

	assign dbg_word0 = mem[0];
	assign dbg_word1 = mem[1];
	assign dbg_word2 = mem[2];
	assign dbg_word3 = mem[3];

endmodule

// ==== mem_access_ctrl.sv ====
`timescale 1ns/1ps

module mem_access_ctrl
(
	input  mem_stage_pkg::mem_op_t   mem_op,         // Memory opcode of the current instruction
	input  mem_stage_pkg::br_op_t    br_op,          // Branch opcode of the current instruction
	input  logic                     zero,           // ALU zero flag from execute
	output logic                     mem_write,      // Write strobe to the data memory
	output mem_stage_pkg::acc_size_t store_size,     // How the store data is shaped
	output mem_stage_pkg::acc_size_t load_size,      // How the read word is extended
	output logic                     load_unsigned,  // Zero-extend instead of sign-extend
	output logic                     pc_src          // Branch taken, selects pc_target
);

	import mem_stage_pkg::*;

	// Opcode decode, the datapath blocks only ever see these flags
	always_comb
	begin
		mem_write     = 1'b0;
		store_size    = SIZE_WORD;
		load_size     = SIZE_WORD;  // Non-loads pass the raw word through
		load_unsigned = 1'b0;
		case (mem_op)
			MEM_NONE:
			begin
				mem_write = 1'b0;
			end
			MEM_LW:
			begin
				load_size = SIZE_WORD;
			end
			MEM_LH:
			begin
				load_size = SIZE_HALF;
			end
			MEM_LHU:
			begin
				load_size     = SIZE_HALF;
				load_unsigned = 1'b1;
			end
			MEM_LB:
			begin
				load_size = SIZE_BYTE;
			end
			MEM_LBU:
			begin
				load_size     = SIZE_BYTE;
				load_unsigned = 1'b1;
			end
			MEM_SW:
			begin
				mem_write  = 1'b1;
				store_size = SIZE_WORD;
			end
			MEM_SH:
			begin
				mem_write  = 1'b1;
				store_size = SIZE_HALF;
			end
			MEM_SB:
			begin
				mem_write  = 1'b1;
				store_size = SIZE_BYTE;
			end
			default:
			begin
				mem_write = 1'b0;  // Unused encodings behave like MEM_NONE
			end
		endcase
	end

	// Branch resolution in the same cycle as the inputs
	always_comb
	begin
		case (br_op)
			BR_EQ:   pc_src = zero;
			BR_NE:   pc_src = ~zero;
			BR_NONE: pc_src = 1'b0;
			default: pc_src = 1'b0;
		endcase
	end

endmodule

// ==== mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage
(
	input  logic                                     clk,
	input  logic                                     reset,

	// From the EX/MEM register
	input  mem_stage_pkg::mem_op_t                   mem_op,
	input  mem_stage_pkg::br_op_t                    br_op,
	input  logic                                     zero,
	input  logic [mem_stage_pkg::data_width-1:0]     alu_result,
	input  logic [mem_stage_pkg::data_width-1:0]     store_data,
	input  logic [mem_stage_pkg::data_width-1:0]     pc_branch,
	input  logic [mem_stage_pkg::wb_ctrl_width-1:0]  wb_ctrl,
	input  logic [mem_stage_pkg::reg_addr_width-1:0] write_reg,
	input  logic                                     halt,

	// Back to fetch
	output logic                                     pc_src,
	output logic [mem_stage_pkg::data_width-1:0]     pc_target,

	// To write-back
	output logic [mem_stage_pkg::data_width-1:0]     read_data,
	output logic [mem_stage_pkg::data_width-1:0]     alu_result_wb,
	output logic [mem_stage_pkg::wb_ctrl_width-1:0]  wb_ctrl_wb,
	output logic [mem_stage_pkg::reg_addr_width-1:0] write_reg_wb,
	output logic                                     halt_wb,

	// To the debug unit
	output logic [mem_stage_pkg::data_width-1:0]     dbg_word0,
	output logic [mem_stage_pkg::data_width-1:0]     dbg_word1,
	output logic [mem_stage_pkg::data_width-1:0]     dbg_word2,
	output logic [mem_stage_pkg::data_width-1:0]     dbg_word3
);

	import mem_stage_pkg::*;

	logic                       mem_write;      // Store strobe from the decoder
	acc_size_t                  store_size;     // Store shaping select
	acc_size_t                  load_size;      // Load extension select
	logic                       load_unsigned;  // Load extension signedness
	logic [mem_index_width-1:0] index;          // Word index taken from the address
	logic [data_width-1:0]      mem_rdata;      // Unextended read word

	assign index     = alu_result[mem_index_width-1:0];
	assign pc_target = pc_branch;  // Target was computed in execute

	mem_access_ctrl i_mem_access_ctrl
	(
		.mem_op        (mem_op),
		.br_op         (br_op),
		.zero          (zero),
		.mem_write     (mem_write),
		.store_size    (store_size),
		.load_size     (load_size),
		.load_unsigned (load_unsigned),
		.pc_src        (pc_src)
	);

	data_memory i_data_memory
	(
		.clk        (clk),
		.reset      (reset),
		.mem_write  (mem_write),
		.store_size (store_size),
		.index      (index),
		.store_data (store_data),
		.mem_rdata  (mem_rdata),
		.dbg_word0  (dbg_word0),
		.dbg_word1  (dbg_word1),
		.dbg_word2  (dbg_word2),
		.dbg_word3  (dbg_word3)
	);

	mem_wb_latch i_mem_wb_latch
	(
		.clk           (clk),
		.reset         (reset),
		.mem_rdata     (mem_rdata),
		.load_size     (load_size),
		.load_unsigned (load_unsigned),
		.alu_result    (alu_result),
		.wb_ctrl       (wb_ctrl),
		.write_reg     (write_reg),
		.halt          (halt),
		.read_data     (read_data),
		.alu_result_wb (alu_result_wb),
		.wb_ctrl_wb    (wb_ctrl_wb),
		.write_reg_wb  (write_reg_wb),
		.halt_wb       (halt_wb)
	);

endmodule

// ==== mem_stage_pkg.sv ====
package mem_stage_pkg;

	// Datapath widths shared by the whole memory stage
	localparam int data_width      = 32;  // Data, address and PC width
	localparam int reg_addr_width  = 5;   // Register file index
	localparam int mem_words       = 64;  // Data memory depth in words
	localparam int mem_index_width = 6;   // Address bits that select a word
	localparam int wb_ctrl_width   = 2;   // Write-back control bits carried along

	// Memory operation requested by the instruction in this stage
	typedef enum logic [3:0]
	{
		MEM_NONE = 4'd0,  // No memory access
		MEM_LW   = 4'd1,  // Load word
		MEM_LH   = 4'd2,  // Load halfword, sign-extended
		MEM_LHU  = 4'd3,  // Load halfword, zero-extended
		MEM_LB   = 4'd4,  // Load byte, sign-extended
		MEM_LBU  = 4'd5,  // Load byte, zero-extended
		MEM_SW   = 4'd6,  // Store word
		MEM_SH   = 4'd7,  // Store halfword over the whole word
		MEM_SB   = 4'd8   // Store byte over the whole word
	} mem_op_t;

	// Conditional branch resolved in this stage
	typedef enum logic [1:0]
	{
		BR_NONE = 2'd0,  // Not a branch
		BR_EQ   = 2'd1,  // Taken when the ALU result was zero
		BR_NE   = 2'd2   // Taken when the ALU result was not zero
	} br_op_t;

	// Access size shared by the store shaper and the load extender
	typedef enum logic [1:0]
	{
		SIZE_WORD = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_BYTE = 2'd2
	} acc_size_t;

endpackage

// ==== mem_wb_latch.sv ====
`timescale 1ns/1ps

module mem_wb_latch
(
	input  logic                                     clk,
	input  logic                                     reset,
	input  logic [mem_stage_pkg::data_width-1:0]     mem_rdata,      // Raw word from memory
	input  mem_stage_pkg::acc_size_t                 load_size,      // Part of the word to keep
	input  logic                                     load_unsigned,  // Zero-extend when high
	input  logic [mem_stage_pkg::data_width-1:0]     alu_result,     // Address, also a WB source
	input  logic [mem_stage_pkg::wb_ctrl_width-1:0]  wb_ctrl,        // Write-back control bits
	input  logic [mem_stage_pkg::reg_addr_width-1:0] write_reg,      // Destination register
	input  logic                                     halt,           // Halt flag from execute
	output logic [mem_stage_pkg::data_width-1:0]     read_data,
	output logic [mem_stage_pkg::data_width-1:0]     alu_result_wb,
	output logic [mem_stage_pkg::wb_ctrl_width-1:0]  wb_ctrl_wb,
	output logic [mem_stage_pkg::reg_addr_width-1:0] write_reg_wb,
	output logic                                     halt_wb
);

	import mem_stage_pkg::*;

	logic [data_width-1:0] load_word;  // Read word after extension
	logic                  half_fill;  // Fill bit for a halfword load
	logic                  byte_fill;  // Fill bit for a byte load

	assign half_fill = load_unsigned ? 1'b0 : mem_rdata[15];
	assign byte_fill = load_unsigned ? 1'b0 : mem_rdata[7];

	// Extension happens before the register so write-back gets a finished value
	always_comb
	begin
		case (load_size)
			SIZE_HALF:
			begin
				load_word = {{(data_width-16){half_fill}}, mem_rdata[15:0]};
			end
			SIZE_BYTE:
			begin
				load_word = {{(data_width-8){byte_fill}}, mem_rdata[7:0]};
			end
			SIZE_WORD:
			begin
				load_word = mem_rdata;
			end
			default:
			begin
				load_word = mem_rdata;
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			read_data     <= '0;
			alu_result_wb <= '0;
			wb_ctrl_wb    <= '0;  // No register write right after reset
			write_reg_wb  <= '0;
			halt_wb       <= 1'b0;
		end
		else
		begin
			read_data     <= load_word;
			alu_result_wb <= alu_result;
			wb_ctrl_wb    <= wb_ctrl;
			write_reg_wb  <= write_reg;
			halt_wb       <= halt;
		end
	end

endmodule

// ==== tb_mem_stage.sv ====
`timescale 1ns/1ps

module tb_mem_stage;

	import mem_stage_pkg::*;

	// One instruction presented to the stage for one cycle
	typedef struct packed
	{
		mem_op_t                   op;
		br_op_t                    br;
		logic                      zero;
		logic [data_width-1:0]     addr;
		logic [data_width-1:0]     data;
		logic [data_width-1:0]     pc;
		logic [wb_ctrl_width-1:0]  wb;
		logic [reg_addr_width-1:0] rd;
		logic                      halt;
	} stim_t;

	logic                      clk;
	logic                      reset;
	mem_op_t                   mem_op;
	br_op_t                    br_op;
	logic                      zero;
	logic [data_width-1:0]     alu_result;
	logic [data_width-1:0]     store_data;
	logic [data_width-1:0]     pc_branch;
	logic [wb_ctrl_width-1:0]  wb_ctrl;
	logic [reg_addr_width-1:0] write_reg;
	logic                      halt;

	logic                      pc_src;
	logic [data_width-1:0]     pc_target;
	logic [data_width-1:0]     read_data;
	logic [data_width-1:0]     alu_result_wb;
	logic [wb_ctrl_width-1:0]  wb_ctrl_wb;
	logic [reg_addr_width-1:0] write_reg_wb;
	logic                      halt_wb;
	logic [data_width-1:0]     dbg_word0;
	logic [data_width-1:0]     dbg_word1;
	logic [data_width-1:0]     dbg_word2;
	logic [data_width-1:0]     dbg_word3;

	stim_t                     stim_q[$];                  // Stimulus table
	logic                      stim_ready = 1'b0;          // Table is built
	logic [data_width-1:0]     model_mem [mem_words];      // Reference copy of the memory
	logic [data_width-1:0]     lcg_state = 32'd71;
	int                        errors = 0;

	// Expected latched values for the instruction driven in the previous cycle
	logic [data_width-1:0]     exp_read_data  = '0;
	logic [data_width-1:0]     exp_alu_result = '0;
	logic [wb_ctrl_width-1:0]  exp_wb_ctrl    = '0;
	logic [reg_addr_width-1:0] exp_write_reg  = '0;
	logic                      exp_halt       = 1'b0;
	logic                      exp_pc_src     = 1'b0;
	logic [data_width-1:0]     exp_pc_target  = '0;

	mem_stage i_dut
	(
		.clk           (clk),
		.reset         (reset),
		.mem_op        (mem_op),
		.br_op         (br_op),
		.zero          (zero),
		.alu_result    (alu_result),
		.store_data    (store_data),
		.pc_branch     (pc_branch),
		.wb_ctrl       (wb_ctrl),
		.write_reg     (write_reg),
		.halt          (halt),
		.pc_src        (pc_src),
		.pc_target     (pc_target),
		.read_data     (read_data),
		.alu_result_wb (alu_result_wb),
		.wb_ctrl_wb    (wb_ctrl_wb),
		.write_reg_wb  (write_reg_wb),
		.halt_wb       (halt_wb),
		.dbg_word0     (dbg_word0),
		.dbg_word1     (dbg_word1),
		.dbg_word2     (dbg_word2),
		.dbg_word3     (dbg_word3)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;  // 4 ns period

	function automatic logic [data_width-1:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic is_store(input mem_op_t op);
		return (op == MEM_SW) || (op == MEM_SH) || (op == MEM_SB);
	endfunction

	// Half and byte stores fill the whole word with the extended value
	function automatic logic [data_width-1:0] shape_store(input mem_op_t op,
		input logic [data_width-1:0] data);
		case (op)
			MEM_SH:  return {{(data_width-16){data[15]}}, data[15:0]};
			MEM_SB:  return {{(data_width-8){data[7]}}, data[7:0]};
			default: return data;
		endcase
	endfunction

	function automatic logic [data_width-1:0] extend_load(input mem_op_t op,
		input logic [data_width-1:0] word);
		case (op)
			MEM_LH:  return {{(data_width-16){word[15]}}, word[15:0]};
			MEM_LHU: return {{(data_width-16){1'b0}}, word[15:0]};
			MEM_LB:  return {{(data_width-8){word[7]}}, word[7:0]};
			MEM_LBU: return {{(data_width-8){1'b0}}, word[7:0]};
			default: return word;  // Word loads and non-loads keep the raw word
		endcase
	endfunction

	function automatic logic branch_taken(input br_op_t br, input logic z);
		case (br)
			BR_EQ:   return z;
			BR_NE:   return ~z;
			default: return 1'b0;
		endcase
	endfunction

	task automatic check_word(input string name, input logic [data_width-1:0] expected,
		input logic [data_width-1:0] actual);
		if (actual !== expected)
		begin
			errors++;
			$display("MISMATCH at %0t ns: %s expected %h actual %h", $time, name,
				expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			errors++;
			$display("MISMATCH at %0t ns: %s expected %b actual %b", $time, name,
				expected, actual);
		end
	endtask

	task automatic check_reg(input string name, input logic [reg_addr_width-1:0] expected,
		input logic [reg_addr_width-1:0] actual);
		if (actual !== expected)
		begin
			errors++;
			$display("MISMATCH at %0t ns: %s expected %0d actual %0d", $time, name,
				expected, actual);
		end
	endtask

	task automatic check_ctrl(input string name, input logic [wb_ctrl_width-1:0] expected,
		input logic [wb_ctrl_width-1:0] actual);
		if (actual !== expected)
		begin
			errors++;
			$display("MISMATCH at %0t ns: %s expected %b actual %b", $time, name,
				expected, actual);
		end
	endtask

	task automatic add_entry(input mem_op_t op, input br_op_t br, input logic z,
		input logic [data_width-1:0] addr, input logic [data_width-1:0] data);
		stim_t                 s;
		logic [data_width-1:0] r;
		r      = lcg_next();
		s.op   = op;
		s.br   = br;
		s.zero = z;
		s.addr = addr;
		s.data = data;
		s.wb   = r[17:16];
		s.rd   = r[24:20];
		s.halt = r[28];
		s.pc   = lcg_next();
		stim_q.push_back(s);
	endtask

	task automatic build_table();
		logic [data_width-1:0] a;
		logic [data_width-1:0] r;
		logic [data_width-1:0] saved_addr [4];
		for (int k = 0; k < mem_words; k++)
		begin
			a = lcg_next();
			add_entry(MEM_LW, BR_NONE, 1'b0, {a[31:6], 6'(k)}, lcg_next());  // Cleared memory
		end
		for (int k = 0; k < 4; k++)
		begin
			add_entry(MEM_SW, BR_NONE, 1'b0, 32'(k), lcg_next());  // Words behind the taps
		end
		for (int k = 0; k < 4; k++)
		begin
			saved_addr[k] = lcg_next();
			add_entry(MEM_SW, BR_NONE, 1'b0, saved_addr[k], lcg_next());
		end
		for (int k = 0; k < 4; k++)
		begin
			add_entry(MEM_LW, BR_NONE, 1'b0, 32'(k), lcg_next());
			add_entry(MEM_LW, BR_NONE, 1'b0, saved_addr[k], lcg_next());
		end
		add_entry(MEM_SW, BR_NONE, 1'b0, 32'd10, lcg_next());
		add_entry(MEM_LW, BR_NONE, 1'b0, 32'd10, lcg_next());  // Load right behind its store
		add_entry(MEM_SH, BR_NONE, 1'b0, 32'd4, 32'h1234_8001);
		add_entry(MEM_SH, BR_NONE, 1'b0, 32'd5, 32'habcd_7ffe);
		add_entry(MEM_SB, BR_NONE, 1'b0, 32'd6, 32'h1111_2280);
		add_entry(MEM_SB, BR_NONE, 1'b0, 32'd7, 32'h00ff_ff7f);
		add_entry(MEM_SH, BR_NONE, 1'b0, 32'd2, lcg_next());
		add_entry(MEM_SB, BR_NONE, 1'b0, 32'd3, lcg_next());
		for (int k = 4; k < 8; k++)
		begin
			add_entry(MEM_LW, BR_NONE, 1'b0, 32'(k), lcg_next());
		end
		add_entry(MEM_SW, BR_NONE, 1'b0, 32'd8, 32'h1234_8086);  // Top bits of half and byte set
		add_entry(MEM_SW, BR_NONE, 1'b0, 32'd9, 32'h8765_7f7f);  // Top bits of half and byte clear
		for (int k = 8; k < 10; k++)
		begin
			add_entry(MEM_LH, BR_NONE, 1'b0, 32'(k), lcg_next());
			add_entry(MEM_LHU, BR_NONE, 1'b0, 32'(k), lcg_next());
			add_entry(MEM_LB, BR_NONE, 1'b0, 32'(k), lcg_next());
			add_entry(MEM_LBU, BR_NONE, 1'b0, 32'(k), lcg_next());
		end
		for (int b = 0; b < 3; b++)
		begin
			add_entry(MEM_NONE, br_op_t'(2'(b)), 1'b0, lcg_next(), lcg_next());
			add_entry(MEM_NONE, br_op_t'(2'(b)), 1'b1, lcg_next(), lcg_next());
		end
		for (int k = 0; k < 24; k++)
		begin
			r = lcg_next();
			a = lcg_next() & 32'hffff_ffcf;  // Keep to words 0 to 15 so loads hit stores
			add_entry(mem_op_t'(4'((r >> 16) % 9)), br_op_t'(2'(r[27:24] % 3)), r[30], a,
				lcg_next());
		end
	endtask

	task automatic drive_entry(input stim_t s);
		logic [mem_index_width-1:0] idx;
		idx        = s.addr[mem_index_width-1:0];
		mem_op     = s.op;
		br_op      = s.br;
		zero       = s.zero;
		alu_result = s.addr;
		store_data = s.data;
		pc_branch  = s.pc;
		wb_ctrl    = s.wb;
		write_reg  = s.rd;
		halt       = s.halt;
		exp_read_data  = extend_load(s.op, model_mem[idx]);  // Read sees memory before the store
		exp_alu_result = s.addr;
		exp_wb_ctrl    = s.wb;
		exp_write_reg  = s.rd;
		exp_halt       = s.halt;
		exp_pc_src     = branch_taken(s.br, s.zero);
		exp_pc_target  = s.pc;
		if (is_store(s.op))
		begin
			model_mem[idx] = shape_store(s.op, s.data);
		end
	endtask

	task automatic check_latched();
		check_word("read_data", exp_read_data, read_data);
		check_word("alu_result_wb", exp_alu_result, alu_result_wb);
		check_ctrl("wb_ctrl_wb", exp_wb_ctrl, wb_ctrl_wb);
		check_reg("write_reg_wb", exp_write_reg, write_reg_wb);
		check_bit("halt_wb", exp_halt, halt_wb);
	endtask

	task automatic check_debug();
		check_word("dbg_word0", model_mem[0], dbg_word0);
		check_word("dbg_word1", model_mem[1], dbg_word1);
		check_word("dbg_word2", model_mem[2], dbg_word2);
		check_word("dbg_word3", model_mem[3], dbg_word3);
	endtask

	initial
	begin
		reset      = 1'b1;
		mem_op     = MEM_SW;  // Busy inputs during reset must not reach the latch or memory
		br_op      = BR_NONE;
		zero       = 1'b0;
		alu_result = 32'h5a5a_5a41;
		store_data = 32'hdead_beef;
		pc_branch  = '0;
		wb_ctrl    = 2'b11;
		write_reg  = 5'd31;
		halt       = 1'b1;
		for (int k = 0; k < mem_words; k++)
		begin
			model_mem[k] = '0;
		end
		build_table();
		stim_ready = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_latched();
		check_debug();
		reset = 1'b0;
		for (int i = 0; i < stim_q.size(); i++)
		begin
			if (i > 0)
			begin
				check_latched();
			end
			check_debug();
			drive_entry(stim_q[i]);
			#1;
			check_word("pc_target", exp_pc_target, pc_target);
			check_bit("pc_src", exp_pc_src, pc_src);
			@(negedge clk);
		end
		check_latched();
		check_debug();
		$display("Applied %0d table entries, %0d errors", stim_q.size(), errors);
		if (errors == 0)
		begin
			$display("RESULT: PASS");
		end
		else
		begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog sized from the table length
	initial
	begin
		wait (stim_ready);
		#((stim_q.size() + 20) * 4);
		$display("Timeout: the stimulus table did not complete in the expected time");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule
